// ==== include/hwce_config.svh ====
// Widths, counts and register map of the convolution engine config slave
// Byte addresses on the bus; bits [1:0] are ignored by the decoder
`ifndef HWCE_CONFIG_SVH
`define HWCE_CONFIG_SVH

// Peripheral bus widths
`define HWCE_ADDR_W 11
`define HWCE_DATA_W 32
`define HWCE_ID_W 16

// Control registers, word index
`define HWCE_REG_TRIGGER 0
`define HWCE_REG_STATUS 1
`define HWCE_REG_CLEAR 2

// Parameter block, word index of first entry and entry count
`define HWCE_PARAM_BASE 8
`define HWCE_N_PARAMS 21

// Offsets inside the parameter block
`define HWCE_P_YOUT 0
`define HWCE_P_YIN 3
`define HWCE_P_XIN 6
`define HWCE_P_XIN_BASE 9
`define HWCE_P_OG_BASE 10
`define HWCE_P_WEIGHT_BASE 18
`define HWCE_P_WEIGHT_SIZE 19
`define HWCE_P_JOB 20

// Output groups and streams
`define HWCE_N_OG_MAX 4
`define HWCE_N_YOUT 4
`define HWCE_N_YIN 4
`define HWCE_N_XIN 12
`define HWCE_N_STREAMS (`HWCE_N_YOUT + `HWCE_N_YIN + `HWCE_N_XIN)

// Address strides
`define HWCE_BANK_SIZE 4096
`define HWCE_WEIGHT_OG_STRIDE 112

`endif

// ==== verilog/hwce_pkg.sv ====
// Shared types of the config slave, sized from hwce_config.svh
// Job word layout is fixed to 32 bits
`include "hwce_config.svh"

package hwce_pkg;

  // Peripheral bus request, one beat per strobe
  typedef struct packed {
    logic                    req;
    // 1 = write, 0 = read
    logic                    data_type;
    logic [`HWCE_ADDR_W-1:0] add;
    logic [`HWCE_DATA_W-1:0] wdata;
    logic [`HWCE_ID_W-1:0]   id;
  } hwce_bus_req_t;

  // Read response, valid the cycle after the request
  typedef struct packed {
    logic [`HWCE_DATA_W-1:0] r_rdata;
    logic [`HWCE_ID_W-1:0]   r_id;
  } hwce_bus_rsp_t;

  // Address generator setup of one memory stream
  typedef struct packed {
    logic [31:0] base_addr;
    logic [31:0] trans_size;
    logic [15:0] line_stride;
    logic [15:0] line_length;
    logic [15:0] feat_stride;
    logic [15:0] feat_length;
  } hwce_stream_cfg_t;

  // Field view of the job word, MSB first
  typedef struct packed {
    logic [8:0]  reserved;
    // Output groups minus one
    logic [1:0]  n_og_m1;
    logic [2:0]  zero_pad;
    logic [1:0]  pool_hw;
    logic        unsigned_mul;
    logic        sum_const;
    logic        rectify;
    // 1 = max pooling, 0 = average
    logic        pool_max;
    logic [11:0] linebuf_length;
  } hwce_job_fields_t;

  // Same word, raw for storage and readback, fields for decode
  typedef union packed {
    logic [31:0]      raw;
    hwce_job_fields_t fields;
  } hwce_job_word_u;

  // Decoded job setup for the current output group
  typedef struct packed {
    logic [31:0] weight_addr;
    logic [15:0] weight_size;
    logic [15:0] weight_mask;
    logic [15:0] linebuf_length;
    logic [15:0] half_width;
    logic [2:0]  zero_pad;
    logic [1:0]  pool_hw;
    logic        pool_max;
    logic        rectify;
    logic        sum_const;
    logic        signed_mul;
  } hwce_job_cfg_t;

  // Whole parameter block, entry 0 at HWCE_PARAM_BASE
  typedef logic [`HWCE_N_PARAMS-1:0][31:0] hwce_params_t;

endpackage

// ==== verilog/hwce_cfg_regfile.sv ====
// Single context register file, no byte enables, writes are full words
// Parameter writes are dropped while a job runs
`include "hwce_config.svh"

module hwce_cfg_regfile (
  input  logic                   clk,
  input  logic                   arst_n_i,
  input  hwce_pkg::hwce_bus_req_t bus_req_i,
  input  logic                   busy_i,
  input  logic [1:0]             og_i,
  output hwce_pkg::hwce_bus_rsp_t bus_rsp_o,
  output hwce_pkg::hwce_params_t  params_o,
  output logic                   trigger_o,
  output logic                   clear_o
);

  localparam int unsigned WIDX_W = `HWCE_ADDR_W - 2;
  localparam int unsigned PIDX_W = $clog2(`HWCE_N_PARAMS);

  logic [WIDX_W-1:0]       word_idx;
  logic [PIDX_W-1:0]       param_idx;
  logic                    is_param;
  logic                    wr_req;
  logic                    rd_req;
  logic [`HWCE_DATA_W-1:0] rdata_d;
  hwce_pkg::hwce_params_t  params_q;
  logic                    trigger_q;
  logic                    clear_q;
  hwce_pkg::hwce_bus_rsp_t rsp_q;

  // Word index, byte lanes dropped
  assign word_idx = bus_req_i.add[`HWCE_ADDR_W-1:2];
  assign param_idx = PIDX_W'(word_idx - WIDX_W'(`HWCE_PARAM_BASE));
  assign is_param = (word_idx >= WIDX_W'(`HWCE_PARAM_BASE)) &&
                    (word_idx < WIDX_W'(`HWCE_PARAM_BASE + `HWCE_N_PARAMS));

  assign wr_req = bus_req_i.req & bus_req_i.data_type;
  assign rd_req = bus_req_i.req & ~bus_req_i.data_type;

  // Parameter storage
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      params_q <= '0;
    end else if (wr_req && is_param && !busy_i) begin
      // Locked while busy so decoded outputs stay stable for the job
      params_q[param_idx] <= bus_req_i.wdata;
    end
  end

  // Trigger and clear strobes, one cycle after the write
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      trigger_q <= 1'b0;
      clear_q   <= 1'b0;
    end else begin
      trigger_q <= wr_req && (word_idx == WIDX_W'(`HWCE_REG_TRIGGER));
      clear_q   <= wr_req && (word_idx == WIDX_W'(`HWCE_REG_CLEAR));
    end
  end

  // Read mux
  always_comb begin
    rdata_d = '0;
    if (word_idx == WIDX_W'(`HWCE_REG_STATUS)) begin
      // Busy at bit 0, group at [3:2]
      rdata_d = {28'b0, og_i, 1'b0, busy_i};
    end else if (is_param) begin
      rdata_d = params_q[param_idx];
    end
  end

  // Registered response, held until the next read
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_q <= '0;
    end else if (rd_req) begin
      rsp_q.r_rdata <= rdata_d;
      rsp_q.r_id    <= bus_req_i.id;
    end
  end

  assign bus_rsp_o = rsp_q;
  assign params_o  = params_q;
  assign trigger_o = trigger_q;
  assign clear_o   = clear_q;

  // Response carries the ID of the read one cycle back
  a_rsp_id: assert property (@(posedge clk) disable iff (!arst_n_i)
    rd_req |=> (bus_rsp_o.r_id == $past(bus_req_i.id)));

endmodule

// ==== verilog/hwce_ctrl_fsm.sv ====
// Runs the engine once per output group, 1 to 4 groups per job
// Engine must not pulse done while idle; clear does not stop the engine itself
module hwce_ctrl_fsm (
  input  logic                     clk,
  input  logic                     arst_n_i,
  input  logic                     trigger_i,
  input  logic                     clear_i,
  input  logic                     done_i,
  input  hwce_pkg::hwce_job_word_u job_word_i,
  output logic                     busy_o,
  output logic                     engine_start_o,
  output logic                     evt_interrupt_o,
  output logic [1:0]               og_o
);

  typedef enum logic {
    IDLE,
    RUN
  } state_e;

  state_e     state_q;
  state_e     state_d;
  logic [1:0] og_q;
  logic [1:0] og_d;
  logic       start_q;
  logic       start_d;
  logic       irq_q;
  logic       irq_d;
  logic       last_og;

  // Group count is fixed for the run, params are locked while busy
  assign last_og = (og_q == job_word_i.fields.n_og_m1);

  always_comb begin
    state_d = state_q;
    og_d    = og_q;
    start_d = 1'b0;
    irq_d   = 1'b0;
    if (clear_i) begin
      // Abort, no interrupt
      state_d = IDLE;
      og_d    = 2'd0;
    end else begin
      unique case (state_q)
        IDLE: begin
          // New job, first group
          if (trigger_i) begin
            state_d = RUN;
            og_d    = 2'd0;
            start_d = 1'b1;
          end
        end
        RUN: begin
          if (done_i) begin
            if (last_og) begin
              state_d = IDLE;
              og_d    = 2'd0;
              irq_d   = 1'b1;
            end else begin
              og_d    = og_q + 2'd1;
              start_d = 1'b1;
            end
          end
        end
        default: state_d = IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      og_q    <= 2'd0;
      start_q <= 1'b0;
      irq_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      og_q    <= og_d;
      start_q <= start_d;
      irq_q   <= irq_d;
    end
  end

  assign busy_o          = (state_q == RUN);
  assign engine_start_o  = start_q;
  assign evt_interrupt_o = irq_q;
  assign og_o            = og_q;

  // Engine only finishes a group that was started
  a_done_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
    (state_q == IDLE) |-> !done_i);

  // Counter stays within the job's group count
  a_og_bound: assert property (@(posedge clk) disable iff (!arst_n_i)
    og_o <= job_word_i.fields.n_og_m1);

endmodule

// ==== verilog/hwce_stream_cfg.sv ====
// Purely combinational stream setup from the parameter block
// Banks of one stream kind are assumed contiguous and HWCE_BANK_SIZE words apart
`include "hwce_config.svh"

module hwce_stream_cfg (
  input  hwce_pkg::hwce_params_t                          params_i,
  input  logic [1:0]                                      og_i,
  output hwce_pkg::hwce_stream_cfg_t [`HWCE_N_STREAMS-1:0] stream_cfg_o
);

  // Byte distance between banks
  localparam logic [31:0] BANK_BYTES = 32'(`HWCE_BANK_SIZE * 4);

  logic [31:0] yout_base;
  logic [31:0] yin_base;

  // Base pair of the current group
  assign yout_base = params_i[`HWCE_P_OG_BASE + 2 * og_i];
  assign yin_base  = params_i[`HWCE_P_OG_BASE + 2 * og_i + 1];

  // Shape words share one layout for every stream kind
  function automatic hwce_pkg::hwce_stream_cfg_t mk_stream(
    input logic [31:0] base,
    input logic [31:0] bank_off,
    input logic [31:0] size_w,
    input logic [31:0] line_w,
    input logic [31:0] feat_w
  );
    hwce_pkg::hwce_stream_cfg_t cfg;
    cfg.base_addr   = base + bank_off;
    cfg.trans_size  = size_w;
    // Stride in the high half and length in the low half
    cfg.line_stride = line_w[31:16];
    cfg.line_length = line_w[15:0];
    cfg.feat_stride = feat_w[31:16];
    cfg.feat_length = feat_w[15:0];
    return cfg;
  endfunction

  // y_out on streams 0..3
  for (genvar j = 0; j < `HWCE_N_YOUT; j++) begin : g_y_out
    assign stream_cfg_o[j] = mk_stream(yout_base, 32'(j) * BANK_BYTES,
                                       params_i[`HWCE_P_YOUT],
                                       params_i[`HWCE_P_YOUT + 1],
                                       params_i[`HWCE_P_YOUT + 2]);
  end

  // y_in on streams 4..7
  for (genvar j = 0; j < `HWCE_N_YIN; j++) begin : g_y_in
    assign stream_cfg_o[`HWCE_N_YOUT + j] = mk_stream(yin_base, 32'(j) * BANK_BYTES,
                                                      params_i[`HWCE_P_YIN],
                                                      params_i[`HWCE_P_YIN + 1],
                                                      params_i[`HWCE_P_YIN + 2]);
  end

  // x_in shares one base across all groups
  for (genvar j = 0; j < `HWCE_N_XIN; j++) begin : g_x_in
    assign stream_cfg_o[`HWCE_N_YOUT + `HWCE_N_YIN + j] =
      mk_stream(params_i[`HWCE_P_XIN_BASE], 32'(j) * BANK_BYTES,
                params_i[`HWCE_P_XIN],
                params_i[`HWCE_P_XIN + 1],
                params_i[`HWCE_P_XIN + 2]);
  end

endmodule

// ==== verilog/hwce_job_cfg.sv ====
// Job setup decode, purely combinational
// Half width assumes an odd weight size of at least 1
`include "hwce_config.svh"

module hwce_job_cfg (
  input  hwce_pkg::hwce_params_t  params_i,
  input  logic [1:0]              og_i,
  output hwce_pkg::hwce_job_cfg_t job_cfg_o
);

  hwce_pkg::hwce_job_word_u job_word;
  logic [15:0]              weight_size;
  logic [15:0]              linebuf_length;

  assign job_word.raw = params_i[`HWCE_P_JOB];

  // Size high half, mask low half
  assign weight_size = params_i[`HWCE_P_WEIGHT_SIZE][31:16];

  // 12-bit field widened to the output width
  assign linebuf_length = {4'b0, job_word.fields.linebuf_length};

  always_comb begin
    // Weights of consecutive groups sit one stride apart
    job_cfg_o.weight_addr    = params_i[`HWCE_P_WEIGHT_BASE] +
                               32'(og_i) * 32'(`HWCE_WEIGHT_OG_STRIDE);
    job_cfg_o.weight_size    = weight_size;
    job_cfg_o.weight_mask    = params_i[`HWCE_P_WEIGHT_SIZE][15:0];
    job_cfg_o.linebuf_length = linebuf_length;
    // Line minus the filter half, border lost to a valid convolution
    job_cfg_o.half_width     = linebuf_length - ((weight_size - 16'd1) >> 1);
    job_cfg_o.zero_pad       = job_word.fields.zero_pad;
    job_cfg_o.pool_hw        = job_word.fields.pool_hw;
    job_cfg_o.pool_max       = job_word.fields.pool_max;
    job_cfg_o.rectify        = job_word.fields.rectify;
    job_cfg_o.sum_const      = job_word.fields.sum_const;
    // Engine takes signed as default
    job_cfg_o.signed_mul     = ~job_word.fields.unsigned_mul;
  end

endmodule

// ==== verilog/hwce_slave_top.sv ====
// Config slave top, bus side plus engine control and decoded setup
// Engine datapath lives outside; done_i is its per-group end pulse
`include "hwce_config.svh"

module hwce_slave_top (
  input  logic                                            clk,
  input  logic                                            arst_n_i,
  input  hwce_pkg::hwce_bus_req_t                         bus_req_i,
  output hwce_pkg::hwce_bus_rsp_t                         bus_rsp_o,
  input  logic                                            done_i,
  output logic                                            engine_start_o,
  output logic                                            busy_o,
  output logic                                            evt_interrupt_o,
  output hwce_pkg::hwce_stream_cfg_t [`HWCE_N_STREAMS-1:0] stream_cfg_o,
  output hwce_pkg::hwce_job_cfg_t                         job_cfg_o
);

  hwce_pkg::hwce_params_t   params;
  hwce_pkg::hwce_job_word_u job_word;
  logic                     trigger;
  logic                     clear;
  logic                     busy;
  logic [1:0]               og;

  // Stored raw, decoded by the FSM through the field view
  assign job_word.raw = params[`HWCE_P_JOB];
  assign busy_o       = busy;

  hwce_cfg_regfile i_cfg_regfile (
    .clk       ( clk       ),
    .arst_n_i  ( arst_n_i  ),
    .bus_req_i ( bus_req_i ),
    .busy_i    ( busy      ),
    .og_i      ( og        ),
    .bus_rsp_o ( bus_rsp_o ),
    .params_o  ( params    ),
    .trigger_o ( trigger   ),
    .clear_o   ( clear     )
  );

  hwce_ctrl_fsm i_ctrl_fsm (
    .clk             ( clk             ),
    .arst_n_i        ( arst_n_i        ),
    .trigger_i       ( trigger         ),
    .clear_i         ( clear           ),
    .done_i          ( done_i          ),
    .job_word_i      ( job_word        ),
    .busy_o          ( busy            ),
    .engine_start_o  ( engine_start_o  ),
    .evt_interrupt_o ( evt_interrupt_o ),
    .og_o            ( og              )
  );

  // Memory stream setup for the current group
  hwce_stream_cfg i_stream_cfg (
    .params_i     ( params       ),
    .og_i         ( og           ),
    .stream_cfg_o ( stream_cfg_o )
  );

  // Weights, line buffer, pooling and activation setup
  hwce_job_cfg i_job_cfg (
    .params_i  ( params    ),
    .og_i      ( og        ),
    .job_cfg_o ( job_cfg_o )
  );

endmodule

// ==== sim/hwce_slave_tb.sv ====
// Table-driven testbench of the config slave; expected values come from a model run at build time
// Trigger rows are only issued from idle, the model does not cover a trigger while busy
`include "hwce_config.svh"

module hwce_slave_tb;

  typedef enum {
    OP_WRITE,
    OP_READ,
    OP_TRIG,
    OP_DONE,
    OP_CLEAR,
    OP_WAIT,
    OP_DECODE
  } op_e;

  // exp is read data, or {busy before, busy, irq, start} for event rows
  typedef struct {
    string                  name;
    op_e                    op;
    logic [10:0]            addr;
    logic [31:0]            data;
    logic [31:0]            exp;
    hwce_pkg::hwce_params_t params;
    logic [1:0]             og;
  } row_t;

  logic                                             clk;
  logic                                             arst_n;
  hwce_pkg::hwce_bus_req_t                          bus_req;
  hwce_pkg::hwce_bus_rsp_t                          bus_rsp;
  logic                                             done;
  logic                                             engine_start;
  logic                                             busy;
  logic                                             irq;
  hwce_pkg::hwce_stream_cfg_t [`HWCE_N_STREAMS-1:0] stream_cfg;
  hwce_pkg::hwce_job_cfg_t                          job_cfg;

  row_t                   table_q[$];
  // Model state while the table is built
  hwce_pkg::hwce_params_t m_params;
  logic                   m_busy;
  logic [1:0]             m_og;
  int                     cycles = 0;
  int                     cycle_limit;
  int                     errors = 0;
  int                     row_errors;
  int                     failed_rows = 0;

  hwce_slave_top i_hwce_slave_top (
    .clk             ( clk          ),
    .arst_n_i        ( arst_n       ),
    .bus_req_i       ( bus_req      ),
    .bus_rsp_o       ( bus_rsp      ),
    .done_i          ( done         ),
    .engine_start_o  ( engine_start ),
    .busy_o          ( busy         ),
    .evt_interrupt_o ( irq          ),
    .stream_cfg_o    ( stream_cfg   ),
    .job_cfg_o       ( job_cfg      )
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: the table did not finish within %0d cycles", cycle_limit);
      $display("Checks failed");
      $finish;
    end
  end

  function automatic logic [10:0] param_addr(input int k);
    return 11'((`HWCE_PARAM_BASE + k) * 4);
  endfunction

  // Streams 0..3 y_out, 4..7 y_in and the rest x_in
  // Banks sit 16 KiB apart
  function automatic hwce_pkg::hwce_stream_cfg_t predict_stream(
    input hwce_pkg::hwce_params_t p,
    input logic [1:0]             og,
    input int                     s
  );
    hwce_pkg::hwce_stream_cfg_t c;
    int                         shape;
    int                         bank;
    logic [31:0]                base;
    if (s < 4) begin
      shape = 0;
      bank  = s;
      base  = p[10 + 2 * int'(og)];
    end else if (s < 8) begin
      shape = 3;
      bank  = s - 4;
      base  = p[11 + 2 * int'(og)];
    end else begin
      shape = 6;
      bank  = s - 8;
      base  = p[9];
    end
    c.base_addr   = base + 32'(bank) * 32'd16384;
    c.trans_size  = p[shape];
    c.line_stride = p[shape + 1][31:16];
    c.line_length = p[shape + 1][15:0];
    c.feat_stride = p[shape + 2][31:16];
    c.feat_length = p[shape + 2][15:0];
    return c;
  endfunction

  function automatic hwce_pkg::hwce_job_cfg_t predict_job(
    input hwce_pkg::hwce_params_t p,
    input logic [1:0]             og
  );
    hwce_pkg::hwce_job_cfg_t c;
    logic [31:0]             job;
    job              = p[20];
    // 112 bytes of weights per output group
    c.weight_addr    = p[18] + 32'(og) * 32'd112;
    c.weight_size    = p[19][31:16];
    c.weight_mask    = p[19][15:0];
    c.linebuf_length = {4'b0, job[11:0]};
    c.half_width     = c.linebuf_length - ((c.weight_size - 16'd1) >> 1);
    c.zero_pad       = job[20:18];
    c.pool_hw        = job[17:16];
    c.pool_max       = job[12];
    c.rectify        = job[13];
    c.sum_const      = job[14];
    c.signed_mul     = !job[15];
    return c;
  endfunction

  // Predicts the row's outcome, then steps the model
  task automatic add_row(input string name, input op_e op, input logic [10:0] addr,
                         input logic [31:0] data);
    row_t r;
    int   idx;
    logic in_params;
    idx       = int'(addr[10:2]);
    in_params = (idx >= 8) && (idx < 8 + 21);
    r.name    = name;
    r.op      = op;
    r.addr    = addr;
    r.data    = data;
    r.exp     = {28'b0, m_busy, 3'b000};
    case (op)
      OP_WRITE: begin
        // Parameters locked during a run
        if (in_params && !m_busy) m_params[idx - 8] = data;
      end
      OP_READ: begin
        if (idx == 1) r.exp = {28'b0, m_og, 1'b0, m_busy};
        else if (in_params) r.exp = m_params[idx - 8];
        else r.exp = '0;
      end
      OP_TRIG: begin
        m_busy   = 1'b1;
        m_og     = 2'd0;
        r.exp[0] = 1'b1;
      end
      OP_DONE: begin
        if (m_og == m_params[20][22:21]) begin
          m_busy   = 1'b0;
          m_og     = 2'd0;
          r.exp[1] = 1'b1;
        end else begin
          m_og     = m_og + 2'd1;
          r.exp[0] = 1'b1;
        end
      end
      OP_CLEAR: begin
        m_busy = 1'b0;
        m_og   = 2'd0;
      end
      default: ;
    endcase
    if (op != OP_READ) r.exp[2] = m_busy;
    r.params = m_params;
    r.og     = m_og;
    table_q.push_back(r);
  endtask

  task automatic build_table();
    logic [31:0] v;
    int          k;
    add_row("reset_param", OP_READ, param_addr(0), $urandom);
    add_row("reset_status", OP_READ, 11'h004, $urandom);
    for (k = 0; k < `HWCE_N_PARAMS; k++) begin
      v = $urandom;
      // Odd filter size 3..9 and three output groups
      if (k == 19) v[31:16] = 16'(2 * ($urandom % 4) + 3);
      if (k == 20) v[22:21] = 2'd2;
      add_row($sformatf("wr_p%0d", k), OP_WRITE, param_addr(k), v);
    end
    for (k = 0; k < `HWCE_N_PARAMS; k++) begin
      add_row($sformatf("rd_p%0d", k), OP_READ, param_addr(k), $urandom);
    end
    add_row("rd_status_idle", OP_READ, 11'h004, $urandom);
    add_row("rd_unmapped_3", OP_READ, 11'h00c, $urandom);
    add_row("rd_unmapped_29", OP_READ, 11'h074, $urandom);
    add_row("wr_unmapped", OP_WRITE, 11'h7fc, $urandom);
    add_row("rd_unmapped_511", OP_READ, 11'h7fe, $urandom);
    add_row("decode_og0", OP_DECODE, 11'h000, 0);
    // Three group run
    add_row("trigger_run", OP_TRIG, 11'h000, 0);
    add_row("rd_status_og0", OP_READ, 11'h004, $urandom);
    add_row("wr_busy_p9", OP_WRITE, param_addr(9), $urandom);
    add_row("wr_busy_job", OP_WRITE, param_addr(20), $urandom);
    add_row("rd_busy_p9", OP_READ, param_addr(9), $urandom);
    add_row("trigger_busy", OP_WRITE, 11'h000, 0);
    add_row("wait_no_start", OP_WAIT, 11'h000, 3);
    add_row("decode_locked", OP_DECODE, 11'h000, 0);
    add_row("done_og0", OP_DONE, 11'h000, 0);
    add_row("rd_status_og1", OP_READ, 11'h004, $urandom);
    add_row("decode_og1", OP_DECODE, 11'h000, 0);
    add_row("done_og1", OP_DONE, 11'h000, 0);
    add_row("decode_og2", OP_DECODE, 11'h000, 0);
    add_row("done_last", OP_DONE, 11'h000, 0);
    add_row("wait_after_irq", OP_WAIT, 11'h000, 3);
    add_row("rd_status_end", OP_READ, 11'h004, $urandom);
    // Abort mid-run, then restart at group 0
    add_row("trigger_again", OP_TRIG, 11'h000, 0);
    add_row("done_og0_b", OP_DONE, 11'h000, 0);
    add_row("clear_mid", OP_CLEAR, 11'h008, 0);
    add_row("wait_no_irq", OP_WAIT, 11'h000, 3);
    add_row("rd_status_clr", OP_READ, 11'h004, $urandom);
    add_row("trigger_restart", OP_TRIG, 11'h000, 0);
    add_row("decode_restart", OP_DECODE, 11'h000, 0);
    add_row("done_og0_c", OP_DONE, 11'h000, 0);
    add_row("done_og1_c", OP_DONE, 11'h000, 0);
    add_row("done_last_c", OP_DONE, 11'h000, 0);
    add_row("rd_status_fin", OP_READ, 11'h004, $urandom);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic report_mismatch(input string test, input string what,
                                 input logic [127:0] exp, input logic [127:0] act);
    $display("[FAIL] %s %s: expected %0h, actual %0h", test, what, exp, act);
    errors++;
    row_errors++;
  endtask

  task automatic apply_row(input row_t r);
    int lat;
    int i;
    bus_req           = '0;
    bus_req.req       = (r.op inside {OP_WRITE, OP_READ, OP_TRIG, OP_CLEAR});
    bus_req.data_type = (r.op != OP_READ);
    bus_req.add       = r.addr;
    bus_req.wdata     = r.data;
    bus_req.id        = r.data[15:0];
    done              = (r.op == OP_DONE);
    next_cycle();
    bus_req = '0;
    done    = 1'b0;
    if (r.op == OP_READ) begin
      if (bus_rsp.r_rdata !== r.exp)
        report_mismatch(r.name, "rdata", r.exp, bus_rsp.r_rdata);
      if (bus_rsp.r_id !== r.data[15:0])
        report_mismatch(r.name, "id", r.data[15:0], bus_rsp.r_id);
    end else if (r.op == OP_DECODE) begin
      for (i = 0; i < `HWCE_N_STREAMS; i++) begin
        if (stream_cfg[i] !== predict_stream(r.params, r.og, i))
          report_mismatch(r.name, $sformatf("stream %0d", i),
                          predict_stream(r.params, r.og, i), stream_cfg[i]);
      end
      if (job_cfg !== predict_job(r.params, r.og))
        report_mismatch(r.name, "job cfg", predict_job(r.params, r.og), job_cfg);
    end else if (r.op != OP_WRITE) begin
      // Done answers after 1 cycle, trigger and clear after 2, wait as given
      lat = (r.op == OP_DONE) ? 1 : ((r.op == OP_WAIT) ? int'(r.data) : 2);
      for (i = 1; i < lat; i++) begin
        if ({busy, irq, engine_start} !== {r.exp[3], 2'b00})
          report_mismatch(r.name, "early busy/irq/start", {r.exp[3], 2'b00},
                          {busy, irq, engine_start});
        next_cycle();
      end
      if ({busy, irq, engine_start} !== r.exp[2:0])
        report_mismatch(r.name, "busy/irq/start", r.exp[2:0], {busy, irq, engine_start});
      // Pulses last one cycle
      next_cycle();
      if ({irq, engine_start} !== 2'b00)
        report_mismatch(r.name, "irq/start after pulse", 2'b00, {irq, engine_start});
    end
  endtask

  initial begin
    clk      = 1'b0;
    arst_n   = 1'b0;
    bus_req  = '0;
    done     = 1'b0;
    void'($urandom(32'h26be_da42));
    m_params = '0;
    m_busy   = 1'b0;
    m_og     = 2'd0;
    build_table();
    cycle_limit = 10 * table_q.size() + 20;
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;
    foreach (table_q[n]) begin
      row_errors = 0;
      apply_row(table_q[n]);
      if (row_errors == 0) begin
        $display("test %-16s passed", table_q[n].name);
      end else begin
        failed_rows++;
        $display("test %-16s had %0d mismatches", table_q[n].name, row_errors);
      end
    end
    $display("%0d tests run, %0d with errors, %0d mismatches",
             table_q.size(), failed_rows, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+include
verilog/hwce_pkg.sv
verilog/hwce_cfg_regfile.sv
verilog/hwce_ctrl_fsm.sv
verilog/hwce_stream_cfg.sv
verilog/hwce_job_cfg.sv
verilog/hwce_slave_top.sv
sim/hwce_slave_tb.sv
